// File: rv_core.f
rv_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_datapath.sv
rv_control.sv
rv_core.sv
tb_clock.sv
tb_rv_core.sv

// File: run.sh
#!/bin/sh
# builds and runs the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_rv_core \
	-f rv_core.f --Mdir obj_dir -o sim_rv_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"
exit 0

// File: tb_rv_core.sv
`default_nettype none

module tb_rv_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] BOOT_VECTOR = 32'h0000_0100;
	localparam logic [31:0] DATA_BASE   = 32'h0000_0280;
	localparam logic [31:0] RESULT_BASE = 32'h0000_0300;
	localparam logic [31:0] MARKER_ADDR = 32'h0000_0400;
	localparam logic [6:0]  OPC_LUI     = 7'b0110111;
	localparam logic [6:0]  OPC_AUIPC   = 7'b0010111;
	localparam logic [6:0]  OPC_JALR    = 7'b1100111;
	localparam logic [6:0]  OPC_LOAD    = 7'b0000011;
	localparam logic [6:0]  OPC_OP_IMM  = 7'b0010011;
	localparam logic [6:0]  OPC_OP      = 7'b0110011;
	// register values set up by the program
	localparam logic [31:0] A  = 32'd7;
	localparam logic [31:0] B  = 32'hFFFF_FFF4;
	localparam logic [31:0] D0 = 32'h1234_8681;
	localparam logic [31:0] D1 = 32'h0000_7F3C;

	logic        pclk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata = 32'd0;
	logic        pready = 1'b0;

	logic [31:0] mem [0:511];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	string       exp_name [$];
	logic [31:0] pc_at;
	logic [11:0] result_off;
	logic [31:0] path_sum;
	int          instr_count;
	logic [31:0] lfsr = 32'h358d_15c3;
	logic [1:0]  wait_left = 2'd0;
	int          xfer_count = 0;
	int          slot = 0;
	logic        done = 1'b0;
	int          value_errors = 0;
	int          setup_errors = 0;
	int          hold_errors = 0;

	tb_clock u_clock (.clk(pclk));

	rv_core #(.RESET_VECTOR_ADDR(32'h0000_0000)) u_dut (
		.pclk(pclk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
	);

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		// taps of x^32 + x^22 + x^2 + x + 1
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic put_instr(input logic [31:0] instr);
		mem[pc_at[10:2]] = instr;
		pc_at += 32'd4;
		instr_count++;
	endtask

	task automatic expect_write(input string name, input logic [31:0] addr,
			input logic [31:0] data);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// x10 holds the base of the result area
	task automatic store_result(input string name, input logic [4:0] rs2,
			input logic [31:0] value);
		put_instr(s_type(result_off, rs2, 5'd10));
		expect_write(name, RESULT_BASE + {20'd0, result_off}, value);
		result_off += 12'd4;
	endtask

	task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input bit taken, input logic [11:0] weight);
		put_instr(b_type(13'd8, rs2, rs1, f3));
		// this add to x20 only runs when the branch falls through
		put_instr(i_type(weight, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
		if (!taken)
			path_sum += {20'd0, weight};
	endtask

	// penable must come in the cycle right after every setup cycle
	a_access_follows_setup: assert property (@(posedge pclk) disable iff (reset)
		psel && !penable |=> psel && penable)
	else begin
		setup_errors++;
		$display("APB setup cycle was not followed by an access cycle");
	end

	a_hold_while_waiting: assert property (@(posedge pclk) disable iff (reset)
		psel && penable && !pready |=> psel && penable && $stable(paddr) && $stable(pwrite)
			&& $stable(pwdata))
	else begin
		hold_errors++;
		$display("APB transfer changed or ended while pready was low");
	end

	// APB memory model, with 0 to 3 wait states drawn for each transfer
	always @(negedge pclk) begin
		logic [31:0] step1;
		logic [31:0] step2;
		if (reset) begin
			pready <= 1'b0;
		end else if (psel && !penable) begin
			step1 = galois_step(lfsr);
			step2 = galois_step(step1);
			wait_left <= {lfsr[0], step1[0]};
			lfsr <= step2;
			pready <= 1'b0;
			if (xfer_count == 0) begin
				assert (paddr == 32'd0 && !pwrite) else begin
					value_errors++;
					$display("[ERROR] boot read: expected %h, actual %h", 32'd0, paddr);
				end
			end else if (xfer_count == 1) begin
				assert (paddr == BOOT_VECTOR && !pwrite) else begin
					value_errors++;
					$display("[ERROR] first fetch: expected %h, actual %h", BOOT_VECTOR, paddr);
				end
			end
			xfer_count <= xfer_count + 1;
		end else if (psel && penable && wait_left != 2'd0) begin
			pready <= 1'b0;
			wait_left <= wait_left - 2'd1;
		end else if (psel && penable) begin
			pready <= 1'b1;
			if (!pwrite) begin
				prdata <= mem[paddr[10:2]];
			end else if (slot >= exp_addr.size()) begin
				value_errors++;
				$display("write to %h came after the last expected write", paddr);
			end else begin
				assert (paddr == exp_addr[slot] && pwdata == exp_data[slot]) else begin
					value_errors++;
					$display("[ERROR] %s: expected %h at %h, actual %h at %h", exp_name[slot],
						exp_data[slot], exp_addr[slot], pwdata, paddr);
				end
			end
			if (pwrite) begin
				slot <= slot + 1;
				if (paddr == MARKER_ADDR)
					done <= 1'b1;
			end
		end else begin
			pready <= 1'b0;
		end
	end

	initial begin
		logic [31:0] p;
		int cycles;
		int limit;
		reset = 1'b1;
		pc_at = BOOT_VECTOR;
		result_off = 12'd0;
		path_sum = 32'd0;
		instr_count = 0;
		cycles = 0;
		mem[0] = BOOT_VECTOR;
		mem[DATA_BASE[10:2]] = D0;
		mem[DATA_BASE[10:2] + 9'd1] = D1;

		put_instr(i_type(RESULT_BASE[11:0], 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
		put_instr(i_type(A[11:0], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
		put_instr(i_type(B[11:0], 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
		put_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		store_result("add", 5'd3, A + B);
		put_instr(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
		store_result("sub", 5'd3, A - B);
		put_instr(i_type({7'h20, 5'd2}, 5'd2, 3'b101, 5'd4, OPC_OP_IMM));
		store_result("srai", 5'd4, $signed(B) >>> 2);
		put_instr(r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd4));
		store_result("sra", 5'd4, $signed(B) >>> 7);
		put_instr(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd5));
		store_result("slt", 5'd5, {31'd0, $signed(B) < $signed(A)});
		put_instr(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd5));
		store_result("sltu", 5'd5, {31'd0, B < A});
		put_instr(r_type(7'h00, 5'd1, 5'd1, 3'b001, 5'd6));
		store_result("sll", 5'd6, A << 7);
		put_instr(i_type(12'd28, 5'd2, 3'b101, 5'd7, OPC_OP_IMM));
		store_result("srli", 5'd7, B >> 28);
		put_instr(i_type(12'h0F0, 5'd2, 3'b111, 5'd8, OPC_OP_IMM));
		store_result("andi", 5'd8, B & 32'h0000_00F0);
		put_instr(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd8));
		store_result("or", 5'd8, A | B);
		put_instr(i_type(12'hFFF, 5'd1, 3'b100, 5'd9, OPC_OP_IMM));
		store_result("xori", 5'd9, ~A);
		put_instr(i_type(12'd5, 5'd2, 3'b010, 5'd9, OPC_OP_IMM));
		store_result("slti", 5'd9, {31'd0, $signed(B) < 32'sd5});

		// loads take the low bits of the word and sign extend them
		put_instr(i_type(DATA_BASE[11:0], 5'd0, 3'b000, 5'd11, OPC_OP_IMM));
		put_instr(i_type(12'd0, 5'd11, 3'b000, 5'd12, OPC_LOAD));
		store_result("lb negative", 5'd12, 32'hFFFF_FF81);
		put_instr(i_type(12'd4, 5'd11, 3'b000, 5'd12, OPC_LOAD));
		store_result("lb positive", 5'd12, 32'h0000_003C);
		put_instr(i_type(12'd0, 5'd11, 3'b001, 5'd12, OPC_LOAD));
		store_result("lh negative", 5'd12, 32'hFFFF_8681);
		put_instr(i_type(12'd4, 5'd11, 3'b001, 5'd12, OPC_LOAD));
		store_result("lh positive", 5'd12, 32'h0000_7F3C);
		put_instr(i_type(12'd0, 5'd11, 3'b010, 5'd12, OPC_LOAD));
		store_result("lw", 5'd12, D0);
		put_instr(u_type(20'hABCDE, 5'd14, OPC_LUI));
		store_result("lui", 5'd14, {20'hABCDE, 12'd0});
		p = pc_at;
		put_instr(u_type(20'h00001, 5'd15, OPC_AUIPC));
		store_result("auipc", 5'd15, p + 32'h0000_1000);

		// each fall-through adds its own weight to x20
		put_instr(i_type(12'd0, 5'd0, 3'b000, 5'd20, OPC_OP_IMM));
		branch_case(3'b000, 5'd1, 5'd2, A == B, 12'd1);
		branch_case(3'b001, 5'd1, 5'd2, A != B, 12'd2);
		branch_case(3'b100, 5'd2, 5'd1, $signed(B) < $signed(A), 12'd4);
		branch_case(3'b101, 5'd2, 5'd1, $signed(B) >= $signed(A), 12'd8);
		branch_case(3'b110, 5'd2, 5'd1, B < A, 12'd16);
		branch_case(3'b111, 5'd2, 5'd1, B >= A, 12'd32);
		store_result("branch path", 5'd20, path_sum);

		p = pc_at;
		put_instr(j_type(21'd8, 5'd21));
		put_instr(i_type(12'd64, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
		store_result("jal link", 5'd21, p + 32'd4);
		// odd offset checks that jalr clears bit 0 of the target
		p = pc_at;
		put_instr(u_type(20'h00000, 5'd23, OPC_AUIPC));
		put_instr(i_type(12'd13, 5'd23, 3'b000, 5'd24, OPC_JALR));
		put_instr(i_type(12'd128, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
		store_result("jalr link", 5'd24, p + 32'd8);
		store_result("jump path", 5'd20, path_sum);

		put_instr(i_type(MARKER_ADDR[11:0], 5'd0, 3'b000, 5'd25, OPC_OP_IMM));
		put_instr(s_type(12'd0, 5'd1, 5'd25));
		expect_write("end marker", MARKER_ADDR, A);
		put_instr(j_type(21'd0, 5'd0));

		// worst case is 12 cycles per instruction with all waits at 3
		limit = 2 * (instr_count * 12 + 16);

		repeat (8) @(negedge pclk);
		reset = 1'b0;
		while (!done && cycles < limit) begin
			@(negedge pclk);
			cycles++;
		end
		if (!done)
			$display("timeout: no end marker store within %0d cycles", limit);
		$display("errors: value %0d, setup %0d, hold %0d", value_errors, setup_errors,
			hold_errors);
		if (done && value_errors == 0 && setup_errors == 0 && hold_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	// free running clock with a 4 ns period
	initial clk = 1'b0;
	always #2 clk = ~clk;

endmodule

`default_nettype wire

// File: rv_core.sv
`default_nettype none

module rv_core #(
	parameter logic [31:0] RESET_VECTOR_ADDR = 32'h0000_0000
) (
	input  logic        pclk,
	input  logic        reset,
	output logic        psel,
	output logic        penable,
	output logic        pwrite,
	output logic [31:0] paddr,
	output logic [31:0] pwdata,
	input  logic [31:0] prdata,
	input  logic        pready
);
	import rv_pkg::*;

	dp_ctrl_t    ctrl;
	apb_req_t    apb_req;
	alu_op_e     alu_op;
	logic [31:0] instruction;
	logic [31:0] pc;
	logic [31:0] next_pc;
	logic [31:0] load_data;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [31:0] wb_data;
	logic [31:0] opa;
	logic [31:0] opb;
	logic [31:0] alu_out;
	logic        branch_taken;
	logic        rd_we;

	rv_control #(.RESET_VECTOR_ADDR(RESET_VECTOR_ADDR)) u_control (
		.pclk(pclk), .reset(reset), .prdata(prdata), .pready(pready),
		.branch_taken(branch_taken), .next_pc(next_pc), .psel(psel), .penable(penable),
		.ctrl(ctrl), .instruction(instruction), .pc(pc), .load_data(load_data),
		.rd_we(rd_we)
	);

	rv_datapath #(.RESET_VECTOR_ADDR(RESET_VECTOR_ADDR)) u_datapath (
		.ctrl(ctrl), .instruction(instruction), .pc(pc), .load_data(load_data),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .alu_out(alu_out), .opa(opa),
		.opb(opb), .alu_op(alu_op), .next_pc(next_pc), .wb_data(wb_data),
		.apb_req(apb_req)
	);

	rv_alu u_alu (
		.opa(opa), .opb(opb), .alu_op(alu_op), .funct3(instruction[14:12]),
		.alu_out(alu_out), .branch_taken(branch_taken)
	);

	rv_regfile u_regfile (
		.pclk(pclk), .reset(reset), .rs1_addr(instruction[19:15]),
		.rs2_addr(instruction[24:20]), .rd_addr(instruction[11:7]), .rd_we(rd_we),
		.wb_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	assign paddr  = apb_req.paddr;
	assign pwdata = apb_req.pwdata;
	assign pwrite = apb_req.pwrite;

endmodule

`default_nettype wire

// File: rv_control.sv
`default_nettype none

module rv_control #(
	parameter logic [31:0] RESET_VECTOR_ADDR = 32'h0000_0000
) (
	input  logic             pclk,
	input  logic             reset,
	input  logic [31:0]      prdata,
	input  logic             pready,
	input  logic             branch_taken,
	input  logic [31:0]      next_pc,
	output logic             psel,
	output logic             penable,
	output rv_pkg::dp_ctrl_t ctrl,
	output logic [31:0]      instruction,
	output logic [31:0]      pc,
	output logic [31:0]      load_data,
	output logic             rd_we
);
	import rv_pkg::*;

	typedef enum logic [2:0] {
		st_boot_setup,
		st_boot_access,
		st_fetch_setup,
		st_fetch_access,
		st_execute,
		st_mem_setup,
		st_mem_access,
		st_writeback
	} state_e;

	state_e   state;
	state_e   next_state;
	opcode_e  opcode;
	logic     boot_done;
	logic     opcode_valid;
	logic     is_mem;
	logic     is_store;
	logic     exec_we;
	logic     pc_load;
	wb_sel_e  exec_wb_sel;
	pc_sel_e  exec_pc_sel;
	opb_sel_e dec_opb_sel;

	assign opcode = opcode_e'(instruction[6:0]);

	// decode of the instruction register, used from execute onwards
	always_comb begin
		opcode_valid = 1'b1;
		is_mem       = 1'b0;
		is_store     = 1'b0;
		exec_we      = 1'b0;
		pc_load      = 1'b0;
		exec_wb_sel  = wb_alu;
		exec_pc_sel  = pc_plus4;
		dec_opb_sel  = opb_rs2;
		case (opcode)
			opc_lui, opc_auipc: begin
				exec_we     = 1'b1;
				exec_wb_sel = wb_upper;
			end
			opc_jal: begin
				exec_we     = 1'b1;
				exec_wb_sel = wb_link;
				exec_pc_sel = pc_jal;
				pc_load     = 1'b1;
			end
			opc_jalr: begin
				exec_we     = 1'b1;
				exec_wb_sel = wb_link;
				exec_pc_sel = pc_jalr;
				dec_opb_sel = opb_imm_i;
				pc_load     = 1'b1;
			end
			opc_branch: begin
				// a branch not taken keeps the pc advanced at fetch
				exec_pc_sel = branch_taken ? pc_branch : pc_plus4;
				pc_load     = branch_taken;
			end
			opc_load: begin
				is_mem      = 1'b1;
				dec_opb_sel = opb_imm_i;
			end
			opc_store: begin
				is_mem      = 1'b1;
				is_store    = 1'b1;
				dec_opb_sel = opb_imm_s;
			end
			opc_op_imm: begin
				exec_we     = 1'b1;
				dec_opb_sel = opb_imm_i;
			end
			opc_op: exec_we = 1'b1;
			default: opcode_valid = 1'b0;
		endcase
	end

	always_comb begin
		ctrl.pc_sel   = pc_plus4;
		ctrl.wb_sel   = wb_alu;
		ctrl.opb_sel  = dec_opb_sel;
		ctrl.addr_sel = addr_pc;
		ctrl.alu_add  = (opcode == opc_load) || (opcode == opc_store) || (opcode == opc_jalr);
		rd_we         = 1'b0;
		case (state)
			st_boot_setup, st_boot_access: ctrl.addr_sel = addr_boot;
			st_execute: begin
				ctrl.pc_sel = exec_pc_sel;
				ctrl.wb_sel = exec_wb_sel;
				rd_we       = exec_we;
			end
			st_mem_setup, st_mem_access: ctrl.addr_sel = addr_alu;
			st_writeback: begin
				// the first writeback after reset carries the boot vector
				ctrl.pc_sel = boot_done ? pc_plus4 : pc_boot;
				ctrl.wb_sel = wb_load;
				rd_we       = boot_done;
			end
			default: ctrl.addr_sel = addr_pc;
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			st_boot_setup:   next_state = psel ? st_boot_access : st_boot_setup;
			st_boot_access:  next_state = pready ? st_writeback : st_boot_access;
			st_fetch_setup:  next_state = st_fetch_access;
			st_fetch_access: next_state = pready ? st_execute : st_fetch_access;
			st_execute:      next_state = is_mem ? st_mem_setup : st_fetch_setup;
			st_mem_setup:    next_state = st_mem_access;
			st_mem_access: begin
				if (pready)
					next_state = is_store ? st_fetch_setup : st_writeback;
			end
			default:         next_state = st_fetch_setup;
		endcase
	end

	always_ff @(posedge pclk) begin
		if (reset) begin
			state       <= st_boot_setup;
			psel        <= 1'b0;
			penable     <= 1'b0;
			boot_done   <= 1'b0;
			pc          <= '0;
			instruction <= '0;
		end else begin
			state   <= next_state;
			psel    <= next_state inside {st_boot_setup, st_boot_access, st_fetch_setup,
				st_fetch_access, st_mem_setup, st_mem_access};
			penable <= next_state inside {st_boot_access, st_fetch_access, st_mem_access};
			if (state == st_fetch_access && pready) begin
				instruction <= prdata;
				pc          <= next_pc;
			end
			if (state == st_execute && pc_load)
				pc <= next_pc;
			if (state == st_writeback && !boot_done) begin
				pc        <= next_pc;
				boot_done <= 1'b1;
			end
		end
	end

	// boot vector and load data share one register
	always_ff @(posedge pclk) begin
		if (pready && (state == st_boot_access || (state == st_mem_access && !is_store)))
			load_data <= prdata;
	end

	a_psel_fall: assert property (@(posedge pclk) disable iff (reset)
		$fell(psel) |-> $past(pready && penable));

	// an access cycle always sits under psel that was already raised for setup
	a_penable_psel: assert property (@(posedge pclk) disable iff (reset)
		penable |-> psel && $past(psel));

	a_opcode_known: assert property (@(posedge pclk) disable iff (reset)
		(state == st_execute) |-> opcode_valid);

	// a vector pointing back at its own slot would run the vector as code
	a_boot_vector: assert property (@(posedge pclk) disable iff (reset)
		(state == st_writeback && !boot_done)
			|-> (load_data[1:0] == 2'b00 && load_data != RESET_VECTOR_ADDR));

endmodule

`default_nettype wire

// File: rv_datapath.sv
`default_nettype none

module rv_datapath #(
	parameter logic [31:0] RESET_VECTOR_ADDR = 32'h0000_0000
) (
	input  rv_pkg::dp_ctrl_t ctrl,
	input  logic [31:0]      instruction,
	input  logic [31:0]      pc,
	input  logic [31:0]      load_data,
	input  logic [31:0]      rs1_data,
	input  logic [31:0]      rs2_data,
	input  logic [31:0]      alu_out,
	output logic [31:0]      opa,
	output logic [31:0]      opb,
	output rv_pkg::alu_op_e  alu_op,
	output logic [31:0]      next_pc,
	output logic [31:0]      wb_data,
	output rv_pkg::apb_req_t apb_req
);
	import rv_pkg::*;

	logic [31:0] old_pc;
	logic [2:0]  funct3;
	opcode_e     opcode;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [2:0]  addr_hot;
	logic [4:0]  pc_hot;

	// pc was advanced during fetch, so targets are relative to pc - 4
	assign old_pc = pc - 32'd4;
	assign funct3 = instruction[14:12];
	assign opcode = opcode_e'(instruction[6:0]);

	assign imm_i = {{21{instruction[31]}}, instruction[30:20]};
	assign imm_s = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
	assign imm_b = {{20{instruction[31]}}, instruction[7], instruction[30:25],
		instruction[11:8], 1'b0};
	assign imm_u = {instruction[31:12], 12'b0};
	assign imm_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
		instruction[30:21], 1'b0};

	always_comb begin
		case (ctrl.addr_sel)
			addr_alu:  apb_req.paddr = alu_out;
			addr_boot: apb_req.paddr = RESET_VECTOR_ADDR;
			default:   apb_req.paddr = pc;
		endcase
		apb_req.pwrite = (ctrl.addr_sel == addr_alu) && (opcode == opc_store);
		apb_req.pwdata = apb_req.pwrite ? rs2_data : 32'd0;
	end

	always_comb begin
		case (ctrl.pc_sel)
			pc_jal:    next_pc = old_pc + imm_j;
			pc_branch: next_pc = old_pc + imm_b;
			pc_jalr:   next_pc = {alu_out[31:1], 1'b0};
			pc_boot:   next_pc = load_data;
			default:   next_pc = pc + 32'd4;
		endcase
	end

	always_comb begin
		case (ctrl.wb_sel)
			wb_link: wb_data = pc;
			wb_load: begin
				// word addressed memory, so lb and lh take the low bits
				case (funct3)
					3'b000:  wb_data = {{24{load_data[7]}}, load_data[7:0]};
					3'b001:  wb_data = {{16{load_data[15]}}, load_data[15:0]};
					default: wb_data = load_data;
				endcase
			end
			// lui has bit 5 set, auipc adds the old pc held on operand a
			wb_upper: wb_data = imm_u + (instruction[5] ? 32'd0 : opa);
			default:  wb_data = alu_out;
		endcase
	end

	always_comb begin
		opa = (opcode == opc_auipc) ? old_pc : rs1_data;
		case (ctrl.opb_sel)
			opb_imm_i: opb = imm_i;
			opb_imm_s: opb = imm_s;
			default:   opb = rs2_data;
		endcase
		if (ctrl.addr_sel == addr_alu || ctrl.alu_add)
			alu_op = alu_add;
		else if (opcode == opc_op || (opcode == opc_op_imm && funct3[1:0] == 2'b01))
			alu_op = alu_op_e'({instruction[30], funct3});
		else
			alu_op = alu_op_e'({1'b0, funct3});
	end

	assign addr_hot = {ctrl.addr_sel == addr_boot, ctrl.addr_sel == addr_alu,
		ctrl.addr_sel == addr_pc};
	assign pc_hot = {ctrl.pc_sel == pc_boot, ctrl.pc_sel == pc_jalr,
		ctrl.pc_sel == pc_branch, ctrl.pc_sel == pc_jal, ctrl.pc_sel == pc_plus4};

	// each select has to name exactly one source once ctrl is driven
	always_comb begin
		if (!$isunknown(ctrl))
			assert ($onehot(addr_hot) && $onehot(pc_hot))
			else $error("datapath select out of range");
	end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`default_nettype none

module rv_regfile (
	input  logic        pclk,
	input  logic        reset,
	input  logic [4:0]  rs1_addr,
	input  logic [4:0]  rs2_addr,
	input  logic [4:0]  rd_addr,
	input  logic        rd_we,
	input  logic [31:0] wb_data,
	output logic [31:0] rs1_data,
	output logic [31:0] rs2_data
);

	// x0 has no storage and always reads as zero
	logic [31:0] regs [1:31];

	always_ff @(posedge pclk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (rd_we && rd_addr != 5'd0) begin
			regs[rd_addr] <= wb_data;
		end
	end

	assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: rv_alu.sv
`default_nettype none

module rv_alu (
	input  logic [31:0]     opa,
	input  logic [31:0]     opb,
	input  rv_pkg::alu_op_e alu_op,
	input  logic [2:0]      funct3,
	output logic [31:0]     alu_out,
	output logic            branch_taken
);
	import rv_pkg::*;

	logic [4:0] shamt;
	logic       eq;
	logic       lt;
	logic       ltu;

	assign shamt = opb[4:0];
	assign eq    = (opa == opb);
	assign lt    = ($signed(opa) < $signed(opb));
	assign ltu   = (opa < opb);

	always_comb begin
		case (alu_op)
			alu_sub:  alu_out = opa - opb;
			alu_sll:  alu_out = opa << shamt;
			alu_slt:  alu_out = {31'd0, lt};
			alu_sltu: alu_out = {31'd0, ltu};
			alu_xor:  alu_out = opa ^ opb;
			alu_srl:  alu_out = opa >> shamt;
			alu_sra:  alu_out = $signed(opa) >>> shamt;
			alu_or:   alu_out = opa | opb;
			alu_and:  alu_out = opa & opb;
			default:  alu_out = opa + opb;
		endcase
	end

	// branch compare uses funct3 directly, independent of alu_op
	always_comb begin
		case (funct3)
			3'b000:  branch_taken = eq;
			3'b001:  branch_taken = !eq;
			3'b100:  branch_taken = lt;
			3'b101:  branch_taken = !lt;
			3'b110:  branch_taken = ltu;
			3'b111:  branch_taken = !ltu;
			default: branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

	// major opcodes of the RV32I subset handled by the core
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	// encoding is instruction bit 30 followed by funct3
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sub  = 4'b1000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_sra  = 4'b1101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111
	} alu_op_e;

	typedef enum logic [2:0] {
		pc_plus4,
		pc_jal,
		pc_branch,
		pc_jalr,
		pc_boot
	} pc_sel_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_link,
		wb_load,
		wb_upper
	} wb_sel_e;

	typedef enum logic [1:0] {
		opb_rs2,
		opb_imm_i,
		opb_imm_s
	} opb_sel_e;

	typedef enum logic [1:0] {
		addr_pc,
		addr_alu,
		addr_boot
	} addr_sel_e;

	// selects driven by the sequencer into the datapath
	typedef struct packed {
		pc_sel_e   pc_sel;
		wb_sel_e   wb_sel;
		opb_sel_e  opb_sel;
		addr_sel_e addr_sel;
		logic      alu_add;
	} dp_ctrl_t;

	typedef struct packed {
		logic [31:0] paddr;
		logic [31:0] pwdata;
		logic        pwrite;
	} apb_req_t;

endpackage

`default_nettype wire
